/* verilog.f */
gfx_pkg.sv
video_timing.sv
gfx_reg_file.sv
line_fetch.sv
dp_ram.sv
pixel_mixer.sv
gfx_top.sv
tb_gfx.sv

/* tb_gfx.sv */
`timescale 1ns/1ps

module tb_gfx;

	logic        CLK;
	logic        reset;
	logic [11:0] ADDRESS;
	logic [15:0] DATA_IN;
	logic        WR;
	logic [15:0] DATA_OUT;
	logic        HS;
	logic        VS;
	logic [3:0]  RR;
	logic [3:0]  GG;
	logic [3:0]  BB;
	logic [14:0] B_ADDR;
	logic        B_VALID;
	logic [15:0] B_DIN;
	logic        B_READY;

	// Expected register contents.
	logic [14:0] model_base;
	logic [11:0] model_bg;
	logic [11:0] model_pal [16];

	int   hpos;              // Raster position of the pixel at the outputs.
	int   vpos;
	logic synced;
	logic prev_vs;
	logic check_pixels;
	int   skip_line;
	logic stall;             // Bank holds B_READY low.
	int   words_taken;       // Bank words accepted in the current fetch.
	logic prev_valid;

	gfx_top i_dut
	(
		.CLK      (CLK),
		.reset    (reset),
		.ADDRESS  (ADDRESS),
		.DATA_IN  (DATA_IN),
		.WR       (WR),
		.DATA_OUT (DATA_OUT),
		.HS       (HS),
		.VS       (VS),
		.RR       (RR),
		.GG       (GG),
		.BB       (BB),
		.B_ADDR   (B_ADDR),
		.B_VALID  (B_VALID),
		.B_DIN    (B_DIN),
		.B_READY  (B_READY)
	);

	always #10 CLK = ~CLK;

	// Bank model with random stalls.
	always @(posedge CLK)
	begin
		#1;
		B_DIN   = {1'b0, B_ADDR} ^ 16'h5a3c;
		B_READY = !stall && (($urandom % 100) < 60);
	end

	// ------------------------------------------------------------
	// Reference and checks
	// ------------------------------------------------------------
	function automatic logic [11:0] expected_pixel(input int h, input int v);
		logic [14:0] addr;
		logic [15:0] data;
		logic [3:0]  index;
		int          nib;
		nib   = (h / 2) % 4;
		addr  = 15'(model_base + (v / 2) * gfx_pkg::WORDS_PER_LINE + h / 8);
		data  = {1'b0, addr} ^ 16'h5a3c; // Bank content.
		index = data[15 - 4 * nib -: 4];  // Leftmost pixel in the top nibble.
		return (index == 4'd0) ? model_bg : model_pal[index];
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got 0x%h, expected 0x%h (x %0d, y %0d)",
				name, actual, expected, hpos, vpos);
			$display("Testbench failed");
			$fatal(1, "check on %s failed", name);
		end
	endtask

	always @(negedge CLK)
	begin
		if (synced)
		begin
			if (hpos == gfx_pkg::H_TOTAL - 1)
			begin
				hpos = 0;
				vpos = (vpos == gfx_pkg::V_TOTAL - 1) ? 0 : vpos + 1;
			end
			else
				hpos = hpos + 1;
		end
		else if (prev_vs === 1'b1 && VS === 1'b0)
		begin
			synced = 1'b1;
			hpos   = 0;
			vpos   = gfx_pkg::V_LINES + gfx_pkg::V_FRONT;
		end
		prev_vs = VS;
		if (synced)
		begin
			compare("HS", HS, !(hpos >= gfx_pkg::H_PIXELS + gfx_pkg::H_FRONT &&
				hpos < gfx_pkg::H_PIXELS + gfx_pkg::H_FRONT + gfx_pkg::H_SYNC));
			compare("VS", VS, !(vpos >= gfx_pkg::V_LINES + gfx_pkg::V_FRONT &&
				vpos < gfx_pkg::V_LINES + gfx_pkg::V_FRONT + gfx_pkg::V_SYNC));
			if (hpos < gfx_pkg::H_PIXELS && vpos < gfx_pkg::V_LINES)
			begin
				if (check_pixels && vpos != skip_line)
					compare("RR/GG/BB", {RR, GG, BB}, expected_pixel(hpos, vpos));
			end
			else
				compare("RR/GG/BB", {RR, GG, BB}, 0); // Blanking.
		end
	end

	// Each fetch hands over one full bitmap row before B_VALID falls.
	always @(negedge CLK)
	begin
		if (prev_valid === 1'b1 && B_VALID === 1'b0)
		begin
			compare("B_VALID words", words_taken, gfx_pkg::WORDS_PER_LINE);
			words_taken = 0;
		end
		if (B_VALID === 1'b1 && B_READY === 1'b1)
			words_taken = words_taken + 1;
		prev_valid = B_VALID;
	end

	// ------------------------------------------------------------
	// Register bus
	// ------------------------------------------------------------
	task automatic write_reg(input logic [11:0] addr, input logic [15:0] data);
		@(posedge CLK);
		#1;
		while (VS !== 1'b0)
		begin
			@(posedge CLK);
			#1;
		end
		ADDRESS = addr;
		DATA_IN = data;
		WR      = 1'b1;
		@(posedge CLK);
		#1 WR = 1'b0;
	endtask

	task automatic read_reg(input logic [11:0] addr, output logic [15:0] data);
		@(posedge CLK);
		#1 ADDRESS = addr;
		@(negedge CLK);
		data = DATA_OUT;
	endtask

	task automatic wait_vs_fall();
		@(negedge VS);
	endtask

	task automatic wait_position(input int h, input int v);
		do
			@(posedge CLK);
		while (!(hpos == h && vpos == v));
	endtask

	// New base, background and palette, with read-back.
	task automatic configure();
		logic [15:0] data;
		model_base = 15'($urandom);
		model_bg   = 12'($urandom);
		write_reg(gfx_pkg::REG_BASE, {1'b0, model_base});
		write_reg(gfx_pkg::REG_BG_COLOR, {4'd0, model_bg});
		for (int i = 0; i < 16; i++)
		begin
			model_pal[i] = 12'($urandom);
			write_reg({gfx_pkg::PAL_BASE, 4'(i)}, {4'd0, model_pal[i]});
		end
		read_reg(gfx_pkg::REG_BASE, data);
		compare("REG_BASE", data, {1'b0, model_base});
		read_reg(gfx_pkg::REG_BG_COLOR, data);
		compare("REG_BG_COLOR", data, {4'd0, model_bg});
	endtask

	// About four frames of test plus the wait for the first sync.
	initial
	begin
		repeat (6 * gfx_pkg::H_TOTAL * gfx_pkg::V_TOTAL + 20000) @(posedge CLK);
		$display("timeout: the test sequence did not finish in time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		logic [15:0] count_before;
		logic [15:0] count_after;
		logic [15:0] status;
		CLK          = 1'b0;
		reset        = 1'b1;
		ADDRESS      = '0;
		DATA_IN      = '0;
		WR           = 1'b0;
		B_DIN        = '0;
		B_READY      = 1'b0;
		hpos         = 0;
		vpos         = 0;
		synced       = 1'b0;
		prev_vs      = 1'b0;
		check_pixels = 1'b0;
		skip_line    = -1;
		stall        = 1'b0;
		words_taken  = 0;
		prev_valid   = 1'b0;
		void'($urandom(20));
		repeat (10) @(posedge CLK);
		#1 reset = 1'b0;

		wait_vs_fall();
		read_reg(gfx_pkg::REG_FRAME_COUNT, count_before);
		configure();
		check_pixels = 1'b1;

		// Same point one frame later.
		wait_vs_fall();
		read_reg(gfx_pkg::REG_FRAME_COUNT, count_after);
		compare("REG_FRAME_COUNT", count_after, 16'(count_before + 16'd1));
		configure();

		wait_vs_fall();
		read_reg(gfx_pkg::REG_STATUS, status);
		compare("REG_STATUS", status, 16'd0);

		// ------------------------------------------------------------
		// Starve the fetch of line 100
		// ------------------------------------------------------------
		skip_line = 100;
		wait_position(600, 99);
		stall = 1'b1;
		wait_position(640, 100); // Fetch of line 101 has taken over.
		stall = 1'b0;
		wait_position(700, 100);
		read_reg(gfx_pkg::REG_STATUS, status);
		compare("REG_STATUS", status, 16'd1);
		wait_vs_fall();
		write_reg(gfx_pkg::REG_STATUS, 16'hffff);
		read_reg(gfx_pkg::REG_STATUS, status);
		compare("REG_STATUS", status, 16'd0);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* gfx_top.sv */
`timescale 1ns/1ps

module gfx_top
(
	input  logic                                  CLK,
	input  logic                                  reset,
	input  logic [gfx_pkg::ADDRESS_BITS-1:0]      ADDRESS,
	input  gfx_pkg::word_t                        DATA_IN,
	input  logic                                  WR,
	output gfx_pkg::word_t                        DATA_OUT,
	output logic                                  HS,
	output logic                                  VS,
	output logic [3:0]                            RR,
	output logic [3:0]                            GG,
	output logic [3:0]                            BB,
	output logic [gfx_pkg::BANK_ADDRESS_BITS-1:0] B_ADDR,
	output logic                                  B_VALID,
	input  gfx_pkg::word_t                        B_DIN,
	input  logic                                  B_READY
);

	logic [9:0] hcount;
	logic [9:0] vcount;
	logic       hs;
	logic       vs;
	logic       frame_tick;
	logic       fetch_start;
	logic [9:0] fetch_line;

	logic [gfx_pkg::BANK_ADDRESS_BITS-1:0]    base_addr;
	gfx_pkg::color_t                          bg_color;
	logic                                     pal_we;
	logic [gfx_pkg::PAL_ADDRESS_BITS-1:0]     pal_index;
	gfx_pkg::color_t                          pal_data;
	logic                                     underrun;

	logic                                     lb_we;
	logic [gfx_pkg::LINEBUF_ADDRESS_BITS-1:0] lb_addr;
	gfx_pkg::word_t                           lb_data;
	logic [gfx_pkg::LINEBUF_ADDRESS_BITS-1:0] lb_raddr;
	gfx_pkg::word_t                           lb_rdata;

	video_timing i_timing
	(
		.CLK         (CLK),
		.reset       (reset),
		.hcount      (hcount),
		.vcount      (vcount),
		.hs          (hs),
		.vs          (vs),
		.frame_tick  (frame_tick),
		.fetch_start (fetch_start),
		.fetch_line  (fetch_line)
	);

	gfx_reg_file i_regs
	(
		.CLK        (CLK),
		.reset      (reset),
		.ADDRESS    (ADDRESS),
		.DATA_IN    (DATA_IN),
		.WR         (WR),
		.frame_tick (frame_tick),
		.underrun   (underrun),
		.DATA_OUT   (DATA_OUT),
		.base_addr  (base_addr),
		.bg_color   (bg_color),
		.pal_we     (pal_we),
		.pal_index  (pal_index),
		.pal_data   (pal_data)
	);

	line_fetch i_fetch
	(
		.CLK         (CLK),
		.reset       (reset),
		.fetch_start (fetch_start),
		.fetch_line  (fetch_line),
		.base_addr   (base_addr),
		.B_DIN       (B_DIN),
		.B_READY     (B_READY),
		.B_ADDR      (B_ADDR),
		.B_VALID     (B_VALID),
		.lb_we       (lb_we),
		.lb_addr     (lb_addr),
		.lb_data     (lb_data),
		.underrun    (underrun)
	);

	// Ping-pong line buffer, one half per display line parity.
	dp_ram #(.payload_t(gfx_pkg::word_t), .ADDR_BITS(gfx_pkg::LINEBUF_ADDRESS_BITS)) i_linebuf
	(
		.CLK   (CLK),
		.we    (lb_we),
		.waddr (lb_addr),
		.wdata (lb_data),
		.raddr (lb_raddr),
		.rdata (lb_rdata)
	);

	pixel_mixer i_mixer
	(
		.CLK       (CLK),
		.reset     (reset),
		.hcount    (hcount),
		.vcount    (vcount),
		.hs_in     (hs),
		.vs_in     (vs),
		.lb_rdata  (lb_rdata),
		.bg_color  (bg_color),
		.pal_we    (pal_we),
		.pal_index (pal_index),
		.pal_data  (pal_data),
		.lb_raddr  (lb_raddr),
		.RR        (RR),
		.GG        (GG),
		.BB        (BB),
		.HS        (HS),
		.VS        (VS)
	);

endmodule

/* pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer
(
	input  logic                                     CLK,
	input  logic                                     reset,
	input  logic [9:0]                               hcount,
	input  logic [9:0]                               vcount,
	input  logic                                     hs_in,
	input  logic                                     vs_in,
	input  gfx_pkg::word_t                           lb_rdata,
	input  gfx_pkg::color_t                          bg_color,
	input  logic                                     pal_we,
	input  logic [gfx_pkg::PAL_ADDRESS_BITS-1:0]     pal_index,
	input  gfx_pkg::color_t                          pal_data,
	output logic [gfx_pkg::LINEBUF_ADDRESS_BITS-1:0] lb_raddr,
	output logic [3:0]                               RR,
	output logic [3:0]                               GG,
	output logic [3:0]                               BB,
	output logic                                     HS,
	output logic                                     VS
);

	logic                                 active;
	logic [1:0]                           s1_nibble;
	logic                                 s1_active;
	logic                                 s1_hs;
	logic                                 s1_vs;
	logic [gfx_pkg::PAL_ADDRESS_BITS-1:0] s2_index;
	logic                                 s2_active;
	logic                                 s2_hs;
	logic                                 s2_vs;
	logic [gfx_pkg::PAL_ADDRESS_BITS-1:0] pal_raddr;
	gfx_pkg::color_t                      pal_rdata;
	gfx_pkg::color_t                      color;

	assign active = (hcount < 10'(gfx_pkg::H_PIXELS)) && (vcount < 10'(gfx_pkg::V_LINES));

	// Stage 1. Eight screen pixels per buffer word.
	assign lb_raddr = {1'b0, hcount[9:3]} + (vcount[0] ?
		gfx_pkg::LINEBUF_ADDRESS_BITS'(gfx_pkg::WORDS_PER_LINE) : 8'd0);

	// Stage 2. Most significant nibble is the leftmost pixel.
	always_comb
	begin
		case (s1_nibble)
			2'd0:    pal_raddr = lb_rdata[15:12];
			2'd1:    pal_raddr = lb_rdata[11:8];
			2'd2:    pal_raddr = lb_rdata[7:4];
			default: pal_raddr = lb_rdata[3:0];
		endcase
	end

	dp_ram #(.payload_t(gfx_pkg::color_t), .ADDR_BITS(gfx_pkg::PAL_ADDRESS_BITS)) i_palette
	(
		.CLK   (CLK),
		.we    (pal_we),
		.waddr (pal_index),
		.wdata (pal_data),
		.raddr (pal_raddr),
		.rdata (pal_rdata)
	);

	// Stage 3.
	assign color = (s2_index == '0) ? bg_color : pal_rdata;

	always_ff @(posedge CLK)
	begin
		s1_nibble <= hcount[2:1];
		s2_index  <= pal_raddr;
	end

	// ------------------------------------------------------------
	// Active flag and syncs ride along with the pixel
	// ------------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			{s1_active, s1_hs, s1_vs} <= 3'b011;
			{s2_active, s2_hs, s2_vs} <= 3'b011;
			{RR, GG, BB}              <= '0;
			HS                        <= 1'b1;
			VS                        <= 1'b1;
		end
		else
		begin
			{s1_active, s1_hs, s1_vs} <= {active, hs_in, vs_in};
			{s2_active, s2_hs, s2_vs} <= {s1_active, s1_hs, s1_vs};
			{RR, GG, BB}              <= s2_active ? color : 12'd0; // Black in blanking.
			HS                        <= s2_hs;
			VS                        <= s2_vs;
		end
	end

endmodule

/* dp_ram.sv */
`timescale 1ns/1ps

module dp_ram
#(
	parameter type payload_t = gfx_pkg::word_t,
	parameter int  ADDR_BITS = gfx_pkg::LINEBUF_ADDRESS_BITS
)
(
	input  logic                 CLK,
	input  logic                 we,
	input  logic [ADDR_BITS-1:0] waddr,
	input  payload_t             wdata,
	input  logic [ADDR_BITS-1:0] raddr,
	output payload_t             rdata
);

	payload_t mem [2**ADDR_BITS];

	always_ff @(posedge CLK)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr]; // One cycle read.
	end

endmodule

/* line_fetch.sv */
`timescale 1ns/1ps

module line_fetch
(
	input  logic                                     CLK,
	input  logic                                     reset,
	input  logic                                     fetch_start,
	input  logic [9:0]                               fetch_line,
	input  logic [gfx_pkg::BANK_ADDRESS_BITS-1:0]    base_addr,
	input  gfx_pkg::word_t                           B_DIN,
	input  logic                                     B_READY,
	output logic [gfx_pkg::BANK_ADDRESS_BITS-1:0]    B_ADDR,
	output logic                                     B_VALID,
	output logic                                     lb_we,
	output logic [gfx_pkg::LINEBUF_ADDRESS_BITS-1:0] lb_addr,
	output gfx_pkg::word_t                           lb_data,
	output logic                                     underrun
);

	typedef enum logic {S_IDLE, S_REQUEST} state_t;

	state_t     state;
	logic [6:0] word_count;
	logic       half;      // Buffer half being filled.
	logic       accept;
	logic       last_word;
	logic [gfx_pkg::BANK_ADDRESS_BITS-1:0] line_row;
	logic [gfx_pkg::BANK_ADDRESS_BITS-1:0] row_offset;

	assign accept     = (state == S_REQUEST) && B_READY;
	assign last_word  = (word_count == 7'(gfx_pkg::WORDS_PER_LINE - 1));
	assign line_row   = gfx_pkg::BANK_ADDRESS_BITS'(fetch_line[9:1]); // Line doubling.
	assign row_offset = line_row *
		gfx_pkg::BANK_ADDRESS_BITS'(gfx_pkg::WORDS_PER_LINE);

	// ------------------------------------------------------------
	// Request FSM
	// ------------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			state    <= S_IDLE;
			underrun <= 1'b0;
		end
		else
		begin
			underrun <= 1'b0;
			if (fetch_start)
			begin
				// Previous line still short of words.
				underrun <= (state == S_REQUEST) && !(accept && last_word);
				state    <= S_REQUEST;
			end
			else if (accept && last_word)
				state <= S_IDLE;
		end
	end

	// Address and word count follow the accepted words.
	always_ff @(posedge CLK)
	begin
		if (fetch_start)
		begin
			word_count <= '0;
			half       <= fetch_line[0];
			B_ADDR     <= base_addr + row_offset;
		end
		else if (accept)
		begin
			word_count <= word_count + 7'd1;
			B_ADDR     <= B_ADDR + 1'b1;
		end
	end

	assign B_VALID = (state == S_REQUEST);
	assign lb_we   = accept;   // Word is written in the cycle it arrives.
	assign lb_data = B_DIN;
	assign lb_addr = {1'b0, word_count} + (half ?
		gfx_pkg::LINEBUF_ADDRESS_BITS'(gfx_pkg::WORDS_PER_LINE) : 8'd0);

endmodule

/* gfx_reg_file.sv */
`timescale 1ns/1ps

module gfx_reg_file
(
	input  logic                                  CLK,
	input  logic                                  reset,
	input  logic [gfx_pkg::ADDRESS_BITS-1:0]      ADDRESS,
	input  gfx_pkg::word_t                        DATA_IN,
	input  logic                                  WR,
	input  logic                                  frame_tick,
	input  logic                                  underrun,
	output gfx_pkg::word_t                        DATA_OUT,
	output logic [gfx_pkg::BANK_ADDRESS_BITS-1:0] base_addr,
	output gfx_pkg::color_t                       bg_color,
	output logic                                  pal_we,
	output logic [gfx_pkg::PAL_ADDRESS_BITS-1:0]  pal_index,
	output gfx_pkg::color_t                       pal_data
);

	gfx_pkg::word_t frame_count;
	logic           underrun_flag;
	logic           pal_hit;

	assign pal_hit = (ADDRESS[gfx_pkg::ADDRESS_BITS-1:gfx_pkg::PAL_ADDRESS_BITS] ==
		gfx_pkg::PAL_BASE);

	// ------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			base_addr     <= '0;
			bg_color      <= '0;
			pal_we        <= 1'b0;
			frame_count   <= '0;
			underrun_flag <= 1'b0;
		end
		else
		begin
			pal_we <= WR && pal_hit;
			if (WR && ADDRESS == gfx_pkg::REG_BASE)
				base_addr <= DATA_IN[gfx_pkg::BANK_ADDRESS_BITS-1:0];
			if (WR && ADDRESS == gfx_pkg::REG_BG_COLOR)
				bg_color <= gfx_pkg::color_t'(DATA_IN);
			if (frame_tick)
				frame_count <= frame_count + 16'd1;
			if (underrun)
				underrun_flag <= 1'b1; // A new underrun beats the clear.
			else if (WR && ADDRESS == gfx_pkg::REG_STATUS)
				underrun_flag <= 1'b0;
		end
	end

	// Palette entry travels with the strobe.
	always_ff @(posedge CLK)
	begin
		if (WR && pal_hit)
		begin
			pal_index <= ADDRESS[gfx_pkg::PAL_ADDRESS_BITS-1:0];
			pal_data  <= gfx_pkg::color_t'(DATA_IN);
		end
	end

	always_comb
	begin
		case (ADDRESS)
			gfx_pkg::REG_FRAME_COUNT: DATA_OUT = frame_count;
			gfx_pkg::REG_STATUS:      DATA_OUT = {15'd0, underrun_flag};
			gfx_pkg::REG_BASE:        DATA_OUT = gfx_pkg::word_t'(base_addr);
			gfx_pkg::REG_BG_COLOR:    DATA_OUT = gfx_pkg::word_t'(bg_color);
			default:                  DATA_OUT = '0;
		endcase
	end

endmodule

/* video_timing.sv */
`timescale 1ns/1ps

module video_timing
(
	input  logic       CLK,
	input  logic       reset,
	output logic [9:0] hcount,
	output logic [9:0] vcount,
	output logic       hs,
	output logic       vs,
	output logic       frame_tick,
	output logic       fetch_start,
	output logic [9:0] fetch_line
);

	logic [9:0] h_next;
	logic [9:0] v_next;
	logic [9:0] v_after; // Line that follows v_next.

	always_comb
	begin
		h_next = hcount + 10'd1;
		v_next = vcount;
		if (hcount == 10'(gfx_pkg::H_TOTAL - 1))
		begin
			h_next = '0;
			if (vcount == 10'(gfx_pkg::V_TOTAL - 1))
				v_next = '0;
			else
				v_next = vcount + 10'd1;
		end
		v_after = (v_next == 10'(gfx_pkg::V_TOTAL - 1)) ? 10'd0 : v_next + 10'd1;
	end

	// Strobes are worked out from the next count so they line up with it.
	always_ff @(posedge CLK)
	begin
		if (reset)
		begin
			hcount      <= '0;
			vcount      <= '0;
			hs          <= 1'b1;
			vs          <= 1'b1;
			frame_tick  <= 1'b1; // Position (0,0).
			fetch_start <= 1'b0;
			fetch_line  <= 10'd1;
		end
		else
		begin
			hcount      <= h_next;
			vcount      <= v_next;
			hs          <= !(h_next >= 10'(gfx_pkg::H_PIXELS + gfx_pkg::H_FRONT) &&
				h_next < 10'(gfx_pkg::H_PIXELS + gfx_pkg::H_FRONT + gfx_pkg::H_SYNC));
			vs          <= !(v_next >= 10'(gfx_pkg::V_LINES + gfx_pkg::V_FRONT) &&
				v_next < 10'(gfx_pkg::V_LINES + gfx_pkg::V_FRONT + gfx_pkg::V_SYNC));
			frame_tick  <= (h_next == 10'd0) && (v_next == 10'd0);
			fetch_start <= (h_next == 10'(gfx_pkg::H_PIXELS)) &&
				(v_after < 10'(gfx_pkg::V_LINES));
			fetch_line  <= v_after;
		end
	end

endmodule

/* gfx_pkg.sv */
package gfx_pkg;

	// ------------------------------------------------------------
	// Raster, 640x480 at 60 Hz
	// ------------------------------------------------------------
	localparam int H_PIXELS = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_TOTAL  = 800;

	localparam int V_LINES = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC  = 2;
	localparam int V_TOTAL = 525;

	localparam int WORDS_PER_LINE = 80; // 320 pixels at 4 bpp.

	localparam int BITS                 = 16;
	localparam int ADDRESS_BITS         = 12;
	localparam int BANK_ADDRESS_BITS    = 15;
	localparam int LINEBUF_ADDRESS_BITS = 8;
	localparam int PAL_ADDRESS_BITS     = 4;

	// ------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------
	localparam logic [ADDRESS_BITS-1:0] REG_FRAME_COUNT = 12'hf00;
	localparam logic [ADDRESS_BITS-1:0] REG_STATUS      = 12'hf01;
	localparam logic [ADDRESS_BITS-1:0] REG_BASE        = 12'hd00;
	localparam logic [ADDRESS_BITS-1:0] REG_BG_COLOR    = 12'hd01;
	localparam logic [7:0]              PAL_BASE        = 8'he0; // Window 0xe00 to 0xe0f.

	typedef logic [BITS-1:0] word_t;
	typedef logic [11:0] color_t; // Red 11:8, green 7:4, blue 3:0.

endpackage
